// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_ls_stage
RTL_TOP    ?= ls_stage
FILELIST   ?= ls_stage.f
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       rd_en_i,
    input  logic                       wr_en_i,
    input  logic [rv_ls_pkg::XLEN-1:0] addr_i,
    input  logic [rv_ls_pkg::XLEN-1:0] wr_data_i,
    output logic [rv_ls_pkg::XLEN-1:0] rd_data_o,
    output logic                       timer_int_o
);

    logic [rv_ls_pkg::XLEN-1:0] mtime_q;
    logic [rv_ls_pkg::XLEN-1:0] mtimecmp_q;
    logic                       sel_mtime;
    logic                       sel_cmp;

    assign sel_mtime = addr_i == rv_ls_pkg::CLINT_MTIME;
    assign sel_cmp   = addr_i == rv_ls_pkg::CLINT_MTIMECMP;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1; // no interrupt out of reset
        end else begin
            mtime_q <= (wr_en_i && sel_mtime) ? wr_data_i : mtime_q + 1'b1;
            if (wr_en_i && sel_cmp) begin
                mtimecmp_q <= wr_data_i;
            end
        end
    end

    assign rd_data_o = !rd_en_i  ? '0         :
                       sel_mtime ? mtime_q    :
                       sel_cmp   ? mtimecmp_q : '0;

    assign timer_int_o = mtime_q >= mtimecmp_q;

endmodule

`default_nettype wire

// File: csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic [rv_ls_pkg::XLEN-1:0] pc_i,
    input  rv_ls_pkg::instr_u          instr_i,
    input  logic [rv_ls_pkg::XLEN-1:0] csr_wr_data_i,
    input  logic                       trap_i,
    input  logic                       stall_n_i,
    input  logic                       timer_int_i,
    output logic [rv_ls_pkg::XLEN-1:0] csr_data_o,
    output logic [rv_ls_pkg::XLEN-1:0] mtvec_o,
    output logic [rv_ls_pkg::XLEN-1:0] mepc_o,
    output logic                       in_intr_o
);

    logic [rv_ls_pkg::XLEN-1:0] mstatus_q;
    logic [rv_ls_pkg::XLEN-1:0] mie_q;
    logic [rv_ls_pkg::XLEN-1:0] mtvec_q;
    logic [rv_ls_pkg::XLEN-1:0] mepc_q;
    logic [rv_ls_pkg::XLEN-1:0] mcause_q;
    logic [rv_ls_pkg::XLEN-1:0] mip_val;
    logic [rv_ls_pkg::XLEN-1:0] csr_new;
    logic [11:0]                csr_addr;
    logic [2:0]                 f3;
    logic                       is_sys;
    logic                       is_csr;
    logic                       is_mret;
    logic                       csr_we;

    assign is_sys   = instr_i.itype.opcode[6:2] == rv_ls_pkg::OP_SYSTEM;
    assign f3       = instr_i.itype.funct3;
    assign csr_addr = instr_i.itype.imm12;

    assign is_csr  = is_sys && (f3 == rv_ls_pkg::F3_CSRRW || f3 == rv_ls_pkg::F3_CSRRS ||
                                f3 == rv_ls_pkg::F3_CSRRC);
    assign is_mret = is_sys && (f3 == 3'b000) && (csr_addr == rv_ls_pkg::FUNCT12_MRET);

    // set/clear with rs1 = x0 is a pure read
    assign csr_we = is_csr && ((f3 == rv_ls_pkg::F3_CSRRW) || (instr_i.itype.rs1 != 5'd0));

    assign mip_val = {56'd0, timer_int_i, 7'd0}; // MTIP

    always_comb begin
        case (csr_addr)
            rv_ls_pkg::CSR_MSTATUS: csr_data_o = mstatus_q;
            rv_ls_pkg::CSR_MIE:     csr_data_o = mie_q;
            rv_ls_pkg::CSR_MTVEC:   csr_data_o = mtvec_q;
            rv_ls_pkg::CSR_MEPC:    csr_data_o = mepc_q;
            rv_ls_pkg::CSR_MCAUSE:  csr_data_o = mcause_q;
            rv_ls_pkg::CSR_MIP:     csr_data_o = mip_val;
            default:                csr_data_o = '0;
        endcase
    end

    always_comb begin
        case (f3)
            rv_ls_pkg::F3_CSRRS: csr_new = csr_data_o | csr_wr_data_i;
            rv_ls_pkg::F3_CSRRC: csr_new = csr_data_o & ~csr_wr_data_i;
            default:             csr_new = csr_wr_data_i;
        endcase
    end

    // MIE && MTIE && MTIP
    assign in_intr_o = mstatus_q[3] & mie_q[7] & timer_int_i & stall_n_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (stall_n_i) begin
            if (in_intr_o || trap_i) begin
                mepc_q       <= pc_i;
                mcause_q     <= in_intr_o ? rv_ls_pkg::CAUSE_MTI : rv_ls_pkg::CAUSE_ECALL;
                mstatus_q[7] <= mstatus_q[3];
                mstatus_q[3] <= 1'b0;
            end else if (is_mret) begin
                mstatus_q[3] <= mstatus_q[7];
                mstatus_q[7] <= 1'b1;
            end else if (csr_we) begin
                case (csr_addr)
                    rv_ls_pkg::CSR_MSTATUS: mstatus_q <= csr_new;
                    rv_ls_pkg::CSR_MIE:     mie_q     <= csr_new;
                    rv_ls_pkg::CSR_MTVEC:   mtvec_q   <= csr_new;
                    rv_ls_pkg::CSR_MEPC:    mepc_q    <= csr_new;
                    rv_ls_pkg::CSR_MCAUSE:  mcause_q  <= csr_new;
                    default: ; // mip is read only
                endcase
            end
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

`default_nettype wire

// File: ls_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ls_ctrl (
    input  rv_ls_pkg::instr_u          instr_i,
    input  rv_ls_pkg::instr_u          instr_last_i,
    input  logic [rv_ls_pkg::XLEN-1:0] rs2_i,
    input  logic [rv_ls_pkg::XLEN-1:0] wb_data_i,
    output logic                       wren_o,
    output logic                       rden_o,
    output logic [2:0]                 memop_o,
    output logic [rv_ls_pkg::XLEN-1:0] wr_data_o
);

    logic last_is_store;
    logic last_writes_rd;
    logic fwd_hit;

    assign rden_o  = instr_i.itype.opcode[6:2] == rv_ls_pkg::OP_LOAD;
    assign wren_o  = instr_i.stype.opcode[6:2] == rv_ls_pkg::OP_STORE;
    assign memop_o = instr_i.itype.funct3; // same field in both formats

    // previous instr writes a register unless it is a store or targets x0
    assign last_is_store  = instr_last_i.stype.opcode[6:2] == rv_ls_pkg::OP_STORE;
    assign last_writes_rd = ~last_is_store && (instr_last_i.itype.rd != 5'd0);

    assign fwd_hit = last_writes_rd && (instr_last_i.itype.rd == instr_i.stype.rs2);

    // store operand not yet in the register file
    assign wr_data_o = fwd_hit ? wb_data_i : rs2_i;

endmodule

`default_nettype wire

// File: ls_stage.f
rv_ls_pkg.sv
ls_ctrl.sv
lsu.sv
csr_file.sv
clint_timer.sv
ls_stage.sv
tb_ls_stage.sv

// File: ls_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ls_stage (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic [rv_ls_pkg::XLEN-1:0] pc_i,
    input  logic [rv_ls_pkg::XLEN-1:0] alures_i,
    input  logic [rv_ls_pkg::XLEN-1:0] rs2_i,
    input  rv_ls_pkg::instr_u          instr_i,
    input  rv_ls_pkg::instr_u          instr_last_i,
    input  logic [rv_ls_pkg::XLEN-1:0] wb_data_i,
    input  logic                       trap_i,
    input  logic                       stall_n_i,
    input  logic                       sram_rd_valid_i,
    input  logic                       sram_wr_ok_i,
    input  logic [rv_ls_pkg::XLEN-1:0] sram_rd_data_i,
    output logic [rv_ls_pkg::XLEN-1:0] ls_res_o,
    output logic [rv_ls_pkg::XLEN-1:0] csr_data_o,
    output logic [rv_ls_pkg::XLEN-1:0] mtvec_o,
    output logic [rv_ls_pkg::XLEN-1:0] mepc_o,
    output logic                       ls_not_ok_o,
    output logic                       in_intr_o,
    output logic [rv_ls_pkg::XLEN-1:0] sram_addr_o,
    output logic                       sram_rd_en_o,
    output logic                       sram_wr_en_o,
    output logic [rv_ls_pkg::XLEN-1:0] sram_wr_data_o,
    output logic [7:0]                 sram_wr_mask_o,
    output logic [2:0]                 sram_wr_size_o,
    output logic [2:0]                 sram_rd_size_o
);

    logic                       wren;
    logic                       rden;
    logic [2:0]                 memop;
    logic [rv_ls_pkg::XLEN-1:0] wr_data;
    logic                       clint_rd_en;
    logic                       clint_wr_en;
    logic [rv_ls_pkg::XLEN-1:0] clint_addr;
    logic [rv_ls_pkg::XLEN-1:0] clint_wr_data;
    logic [rv_ls_pkg::XLEN-1:0] clint_rd_data;
    logic                       timer_int;

    ls_ctrl ls_ctrl_u (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .wren_o       (wren),
        .rden_o       (rden),
        .memop_o      (memop),
        .wr_data_o    (wr_data)
    );

    lsu lsu_u (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .wren_i          (wren),
        .rden_i          (rden),
        .memop_i         (memop),
        .addr_i          (alures_i), // effective address from the ALU
        .wr_data_i       (wr_data),
        .stall_n_i       (stall_n_i),
        .sram_rd_valid_i (sram_rd_valid_i),
        .sram_wr_ok_i    (sram_wr_ok_i),
        .sram_rd_data_i  (sram_rd_data_i),
        .clint_rd_data_i (clint_rd_data),
        .ls_res_o        (ls_res_o),
        .ls_not_ok_o     (ls_not_ok_o),
        .sram_addr_o     (sram_addr_o),
        .sram_rd_en_o    (sram_rd_en_o),
        .sram_wr_en_o    (sram_wr_en_o),
        .sram_wr_data_o  (sram_wr_data_o),
        .sram_wr_mask_o  (sram_wr_mask_o),
        .sram_wr_size_o  (sram_wr_size_o),
        .sram_rd_size_o  (sram_rd_size_o),
        .clint_rd_en_o   (clint_rd_en),
        .clint_wr_en_o   (clint_wr_en),
        .clint_addr_o    (clint_addr),
        .clint_wr_data_o (clint_wr_data)
    );

    csr_file csr_file_u (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .csr_wr_data_i (alures_i),
        .trap_i        (trap_i),
        .stall_n_i     (stall_n_i),
        .timer_int_i   (timer_int),
        .csr_data_o    (csr_data_o),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o),
        .in_intr_o     (in_intr_o)
    );

    clint_timer clint_timer_u (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rd_en_i     (clint_rd_en),
        .wr_en_i     (clint_wr_en),
        .addr_i      (clint_addr),
        .wr_data_i   (clint_wr_data),
        .rd_data_o   (clint_rd_data),
        .timer_int_o (timer_int)
    );

endmodule

`default_nettype wire

// File: lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       wren_i,
    input  logic                       rden_i,
    input  logic [2:0]                 memop_i,
    input  logic [rv_ls_pkg::XLEN-1:0] addr_i,
    input  logic [rv_ls_pkg::XLEN-1:0] wr_data_i,
    input  logic                       stall_n_i,
    input  logic                       sram_rd_valid_i,
    input  logic                       sram_wr_ok_i,
    input  logic [rv_ls_pkg::XLEN-1:0] sram_rd_data_i,
    input  logic [rv_ls_pkg::XLEN-1:0] clint_rd_data_i,
    output logic [rv_ls_pkg::XLEN-1:0] ls_res_o,
    output logic                       ls_not_ok_o,
    output logic [rv_ls_pkg::XLEN-1:0] sram_addr_o,
    output logic                       sram_rd_en_o,
    output logic                       sram_wr_en_o,
    output logic [rv_ls_pkg::XLEN-1:0] sram_wr_data_o,
    output logic [7:0]                 sram_wr_mask_o,
    output logic [2:0]                 sram_wr_size_o,
    output logic [2:0]                 sram_rd_size_o,
    output logic                       clint_rd_en_o,
    output logic                       clint_wr_en_o,
    output logic [rv_ls_pkg::XLEN-1:0] clint_addr_o,
    output logic [rv_ls_pkg::XLEN-1:0] clint_wr_data_o
);

    logic                       hit_clint;
    logic                       done_q;
    logic                       resp;
    logic [5:0]                 lane_sh;
    logic [7:0]                 size_mask;
    logic [rv_ls_pkg::XLEN-1:0] rd_hold_q;
    logic [rv_ls_pkg::XLEN-1:0] rd_raw;
    logic [rv_ls_pkg::XLEN-1:0] rd_lane;

    assign hit_clint = (addr_i & rv_ls_pkg::CLINT_MASK) == rv_ls_pkg::CLINT_BASE;
    assign lane_sh   = {addr_i[2:0], 3'b000}; // byte offset in bits

    assign sram_rd_en_o  = rden_i & ~hit_clint & ~done_q;
    assign sram_wr_en_o  = wren_i & ~hit_clint & ~done_q;
    assign clint_rd_en_o = rden_i & hit_clint & ~done_q;
    assign clint_wr_en_o = wren_i & hit_clint & ~done_q;

    assign resp        = (sram_rd_en_o & sram_rd_valid_i) | (sram_wr_en_o & sram_wr_ok_i);
    assign ls_not_ok_o = (sram_rd_en_o | sram_wr_en_o) & ~resp;

    always_comb begin
        case (memop_i)
            rv_ls_pkg::F3_B, rv_ls_pkg::F3_BU: size_mask = 8'h01;
            rv_ls_pkg::F3_H, rv_ls_pkg::F3_HU: size_mask = 8'h03;
            rv_ls_pkg::F3_W, rv_ls_pkg::F3_WU: size_mask = 8'h0f;
            default:                           size_mask = 8'hff;
        endcase
    end

    assign sram_addr_o    = addr_i;
    assign sram_wr_data_o = wr_data_i << lane_sh;
    assign sram_wr_mask_o = size_mask << addr_i[2:0];
    assign sram_wr_size_o = {1'b0, memop_i[1:0]}; // log2 of bytes
    assign sram_rd_size_o = {1'b0, memop_i[1:0]};

    assign clint_addr_o    = addr_i;
    assign clint_wr_data_o = wr_data_i;

    // blocks re-issue until the pipeline moves on
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q <= 1'b0;
        end else if (stall_n_i) begin
            done_q <= 1'b0;
        end else if (resp | clint_rd_en_o | clint_wr_en_o) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clint_rd_en_o | (sram_rd_en_o & sram_rd_valid_i)) begin
            rd_hold_q <= rd_raw;
        end
    end

    assign rd_raw = clint_rd_en_o   ? clint_rd_data_i :
                    sram_rd_valid_i ? sram_rd_data_i  : rd_hold_q;

    assign rd_lane = rd_raw >> lane_sh;

    always_comb begin
        case (memop_i)
            rv_ls_pkg::F3_B:  ls_res_o = {{56{rd_lane[7]}}, rd_lane[7:0]};
            rv_ls_pkg::F3_H:  ls_res_o = {{48{rd_lane[15]}}, rd_lane[15:0]};
            rv_ls_pkg::F3_W:  ls_res_o = {{32{rd_lane[31]}}, rd_lane[31:0]};
            rv_ls_pkg::F3_BU: ls_res_o = {56'd0, rd_lane[7:0]};
            rv_ls_pkg::F3_HU: ls_res_o = {48'd0, rd_lane[15:0]};
            rv_ls_pkg::F3_WU: ls_res_o = {32'd0, rd_lane[31:0]};
            default:          ls_res_o = rd_lane;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_ls_pkg.sv
`default_nettype none

package rv_ls_pkg;

    localparam int XLEN     = 64;
    localparam int INST_LEN = 32;

    // opcode bits 6:2
    localparam logic [4:0] OP_LOAD   = 5'b00000;
    localparam logic [4:0] OP_STORE  = 5'b01000;
    localparam logic [4:0] OP_SYSTEM = 5'b11100;

    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MIP     = 12'h344;

    localparam logic [11:0] FUNCT12_MRET = 12'h302;

    localparam logic [XLEN-1:0] CAUSE_ECALL = 64'd11;
    localparam logic [XLEN-1:0] CAUSE_MTI   = {1'b1, 63'd7}; // interrupt bit set

    // core-local timer region
    localparam logic [XLEN-1:0] CLINT_BASE     = 64'h0000_0000_0200_0000;
    localparam logic [XLEN-1:0] CLINT_MTIMECMP = 64'h0000_0000_0200_4000;
    localparam logic [XLEN-1:0] CLINT_MTIME    = 64'h0000_0000_0200_bff8;
    localparam logic [XLEN-1:0] CLINT_MASK     = 64'hffff_ffff_ffff_0000;

    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } itype;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } stype;
    } instr_u;

endpackage

`default_nettype wire

// File: tb_ls_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ls_stage;

    localparam logic [31:0] NOP  = 32'h0000_0013;           // addi x0, x0, 0
    localparam logic [31:0] MRET = 32'h3020_0073;
    localparam int RESET_CYCLES  = 8;
    localparam int ACCESS_CYCLES = 8;                       // issue, up to 3 waits, response
    localparam int N_ACCESSES    = 170;
    localparam int CSR_CYCLES    = 4 * 40;
    localparam int TIMER_CYCLES  = 120;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + ACCESS_CYCLES * N_ACCESSES + CSR_CYCLES + TIMER_CYCLES);

    logic        clk;
    logic        arst_n;
    logic [63:0] pc;
    logic [63:0] alures;
    logic [63:0] rs2;
    rv_ls_pkg::instr_u instr;
    rv_ls_pkg::instr_u instr_last;
    logic [63:0] wb_data;
    logic        trap;
    logic        stall_n;
    logic        sram_rd_valid;
    logic        sram_wr_ok;
    logic [63:0] sram_rd_data;
    logic [63:0] ls_res;
    logic [63:0] csr_data;
    logic [63:0] mtvec;
    logic [63:0] mepc;
    logic        ls_not_ok;
    logic        in_intr;
    logic [63:0] sram_addr;
    logic        sram_rd_en;
    logic        sram_wr_en;
    logic [63:0] sram_wr_data;
    logic [7:0]  sram_wr_mask;
    logic [2:0]  sram_wr_size;
    logic [2:0]  sram_rd_size;

    logic [63:0] sram_mem [0:255];
    logic [7:0]  ref_b [0:2047];   // byte-addressed reference memory
    logic [1:0]  wait_q;
    logic [15:0] lfsr_q;
    int          err_cnt;
    string       cur_test;

    assign stall_n = ~ls_not_ok; // pipeline moves when the stage is ready

    ls_stage dut_i (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .pc_i            (pc),
        .alures_i        (alures),
        .rs2_i           (rs2),
        .instr_i         (instr),
        .instr_last_i    (instr_last),
        .wb_data_i       (wb_data),
        .trap_i          (trap),
        .stall_n_i       (stall_n),
        .sram_rd_valid_i (sram_rd_valid),
        .sram_wr_ok_i    (sram_wr_ok),
        .sram_rd_data_i  (sram_rd_data),
        .ls_res_o        (ls_res),
        .csr_data_o      (csr_data),
        .mtvec_o         (mtvec),
        .mepc_o          (mepc),
        .ls_not_ok_o     (ls_not_ok),
        .in_intr_o       (in_intr),
        .sram_addr_o     (sram_addr),
        .sram_rd_en_o    (sram_rd_en),
        .sram_wr_en_o    (sram_wr_en),
        .sram_wr_data_o  (sram_wr_data),
        .sram_wr_mask_o  (sram_wr_mask),
        .sram_wr_size_o  (sram_wr_size),
        .sram_rd_size_o  (sram_rd_size)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[15:1]} ^ (b ? 16'hb400 : 16'h0000);
        return b;
    endfunction

    function automatic logic [63:0] rand64();
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < 64; i++) begin
            r = {r[62:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic logic [31:0] load_instr(input logic [2:0] f3);
        return {12'd0, 5'd1, f3, 5'd5, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_instr(input logic [2:0] f3, input logic [4:0] rs2_f);
        return {7'd0, rs2_f, 5'd1, f3, 5'd0, 7'b0100011};
    endfunction

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] csr,
                                              input logic [4:0] rs1_f);
        return {csr, rs1_f, f3, 5'd6, 7'b1110011};
    endfunction

    function automatic logic [63:0] expected_load(input logic [2:0] f3, input int addr);
        int n;
        logic [63:0] v;
        n = 1 << f3[1:0];
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[8*b +: 8] = ref_b[addr+b];
        end
        if (!f3[2] && n < 8 && v[8*n-1]) begin
            for (int b = n; b < 8; b++) begin
                v[8*b +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    // SRAM model answering after 0..3 extra cycles
    always @(posedge clk) begin
        sram_rd_valid <= 1'b0;
        sram_wr_ok    <= 1'b0;
        if ((sram_rd_en || sram_wr_en) && !sram_rd_valid && !sram_wr_ok) begin
            if (wait_q == 2'd0) begin
                if (sram_rd_en) begin
                    sram_rd_data  <= sram_mem[sram_addr[10:3]];
                    sram_rd_valid <= 1'b1;
                end else begin
                    for (int k = 0; k < 8; k++) begin
                        if (sram_wr_mask[k]) begin
                            sram_mem[sram_addr[10:3]][8*k +: 8] = sram_wr_data[8*k +: 8];
                        end
                    end
                    sram_wr_ok <= 1'b1;
                end
                wait_q <= {lfsr_bit(), lfsr_bit()};
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        err_cnt++;
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    endtask

    // one load or store held until ls_not_ok_o falls
    task automatic mem_access(input logic [31:0] ins, input logic [31:0] last,
                              input logic [63:0] addr, input logic [63:0] data,
                              output logic [63:0] res, output logic [7:0] mask,
                              output logic [2:0] wsize, output logic [2:0] rsize,
                              output int cycles);
        @(posedge clk);
        instr      <= ins;
        instr_last <= last;
        alures     <= addr;
        rs2        <= data;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ls_not_ok && cycles < 20);
        if (ls_not_ok) begin
            err_cnt++;
            $display("no response from the SRAM for address %h", addr);
        end
        res   = ls_res;
        mask  = sram_wr_mask;
        wsize = sram_wr_size;
        rsize = sram_rd_size;
        if (cycles > 1 && sram_addr !== addr) begin
            report_mismatch({cur_test, " sram_addr"}, addr, sram_addr);
        end
        @(posedge clk);
        instr      <= NOP;
        instr_last <= NOP;
    endtask

    task automatic csr_access(input logic [31:0] ins, input logic [63:0] wdata,
                              output logic [63:0] old);
        @(posedge clk);
        instr  <= ins;
        alures <= wdata;
        @(negedge clk);
        old = csr_data;
        @(posedge clk);
        instr  <= NOP;
        alures <= '0;
        @(negedge clk);
    endtask

    task automatic load_store();
        logic [63:0] d;
        logic [63:0] res;
        logic [7:0]  m;
        logic [7:0]  em;
        logic [2:0]  ws;
        logic [2:0]  rs;
        logic [2:0]  f3;
        int          n;
        int          lg;
        int          addr;
        int          cyc;
        cur_test = "load_store";
        for (int sz = 0; sz < 4; sz++) begin
            n = 1 << sz;
            for (int off = 0; off < 8; off += n) begin
                addr = 'h200 + sz * 8 + off;
                d = rand64();
                mem_access(store_instr(sz[2:0], 5'd2), NOP, 64'(addr), d, res, m, ws, rs, cyc);
                em = '0;
                for (int b = 0; b < n; b++) begin
                    ref_b[addr+b] = d[8*b +: 8];
                    em[off+b] = 1'b1;
                end
                if (m !== em) report_mismatch("load_store mask", 64'(em), 64'(m));
                if (ws !== sz[2:0]) report_mismatch("load_store wr_size", 64'(sz), 64'(ws));
            end
        end
        for (int f = 0; f < 7; f++) begin
            f3 = f[2:0];
            lg = f % 4; // unsigned codes sit four above their signed sizes
            n  = 1 << lg;
            for (int k = 0; k < 4; k++) begin
                for (int off = 0; off < 8; off += n) begin
                    addr = 'h200 + k * 8 + off;
                    mem_access(load_instr(f3), NOP, 64'(addr), '0, res, m, ws, rs, cyc);
                    if (res !== expected_load(f3, addr)) begin
                        report_mismatch("load_store data", expected_load(f3, addr), res);
                    end
                    if (rs !== 3'(lg)) begin
                        report_mismatch("load_store rd_size", 64'(lg), 64'(rs));
                    end
                end
            end
        end
    endtask

    task automatic store_forward();
        logic [4:0]  last_rd [3];
        logic [4:0]  st_rs2 [3];
        logic        fwd_exp [3];
        logic [63:0] res;
        logic [63:0] exp;
        logic [63:0] src;
        logic [7:0]  m;
        logic [2:0]  ws;
        logic [2:0]  rs;
        int          cyc;
        cur_test = "store_forward";
        last_rd = '{5'd5, 5'd7, 5'd0};
        st_rs2  = '{5'd5, 5'd5, 5'd0};
        fwd_exp = '{1'b1, 1'b0, 1'b0};   // match, other rd, x0
        for (int i = 0; i < 3; i++) begin
            src = rand64();
            @(posedge clk);
            wb_data <= rand64();
            @(negedge clk);
            exp = fwd_exp[i] ? wb_data : src;
            mem_access(store_instr(3'b011, st_rs2[i]), {12'd0, 5'd0, 3'b000, last_rd[i], 7'h13},
                       64'h400 + 64'(i * 8), src, res, m, ws, rs, cyc);
            mem_access(load_instr(3'b011), NOP, 64'h400 + 64'(i * 8), '0, res, m, ws, rs, cyc);
            if (res !== exp) report_mismatch("store_forward", exp, res);
        end
    endtask

    task automatic csr_ops();
        logic [2:0]  ops [4];
        logic [4:0]  rs1s [4];
        logic [63:0] vals [4];
        logic [11:0] addr;
        logic [63:0] exp;
        logic [63:0] old;
        logic [63:0] cur;
        ops  = '{3'b001, 3'b010, 3'b011, 3'b010};
        rs1s = '{5'd1, 5'd1, 5'd1, 5'd0};
        vals = '{64'h8000_1000, 64'h0000_000f, 64'h0000_0003, 64'h0000_00ff};
        for (int w = 0; w < 2; w++) begin
            addr = (w == 0) ? 12'h305 : 12'h341;
            exp = '0;
            for (int i = 0; i < 4; i++) begin
                csr_access(csr_instr(ops[i], addr, rs1s[i]), vals[i], old);
                if (old !== exp) report_mismatch("csr_ops old value", exp, old);
                if (ops[i] == 3'b001) exp = vals[i];
                else if (ops[i] == 3'b010 && rs1s[i] != 5'd0) exp = exp | vals[i];
                else if (ops[i] == 3'b011 && rs1s[i] != 5'd0) exp = exp & ~vals[i];
                cur = (w == 0) ? mtvec : mepc;
                if (cur !== exp) report_mismatch("csr_ops new value", exp, cur);
            end
        end
    endtask

    task automatic trap_mret();
        logic [63:0] v;
        csr_access(csr_instr(3'b010, 12'h300, 5'd1), 64'h8, v);   // set MIE
        @(posedge clk);
        pc   <= 64'h8000_0abc;
        trap <= 1'b1;
        @(posedge clk);
        trap <= 1'b0;
        @(negedge clk);
        if (mepc !== 64'h8000_0abc) report_mismatch("trap_mret mepc", 64'h8000_0abc, mepc);
        csr_access(csr_instr(3'b010, 12'h342, 5'd0), '0, v);
        if (v !== 64'd11) report_mismatch("trap_mret mcause", 64'd11, v);
        csr_access(csr_instr(3'b010, 12'h300, 5'd0), '0, v);
        if ((v & 64'h88) !== 64'h80) report_mismatch("trap_mret mstatus", 64'h80, v & 64'h88);
        @(posedge clk);
        instr <= MRET;
        @(posedge clk);
        instr <= NOP;
        csr_access(csr_instr(3'b010, 12'h300, 5'd0), '0, v);
        if ((v & 64'h88) !== 64'h88) report_mismatch("trap_mret mret", 64'h88, v & 64'h88);
    endtask

    task automatic timer_interrupt();
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] v;
        logic [63:0] pc_seen;
        logic [7:0]  m;
        logic [2:0]  ws;
        logic [2:0]  rs;
        int          cyc;
        int          hit_cyc;
        cur_test = "timer_interrupt";
        mem_access(load_instr(3'b011), NOP, rv_ls_pkg::CLINT_MTIME, '0, t1, m, ws, rs, cyc);
        if (cyc != 1) begin
            err_cnt++;
            $display("ls_not_ok_o went high on a timer read");
        end
        mem_access(load_instr(3'b011), NOP, rv_ls_pkg::CLINT_MTIME, '0, t2, m, ws, rs, cyc);
        if (cyc != 1) begin
            err_cnt++;
            $display("ls_not_ok_o went high on a timer read");
        end
        if (!(t2 > t1)) report_mismatch("timer_interrupt mtime increase", t1 + 64'd1, t2);
        csr_access(csr_instr(3'b010, 12'h300, 5'd1), 64'h8, v);
        csr_access(csr_instr(3'b010, 12'h304, 5'd1), 64'h80, v);
        mem_access(load_instr(3'b011), NOP, rv_ls_pkg::CLINT_MTIME, '0, t1, m, ws, rs, cyc);
        mem_access(store_instr(3'b011, 5'd2), NOP, rv_ls_pkg::CLINT_MTIMECMP, t1 + 64'd20,
                   v, m, ws, rs, cyc);
        hit_cyc = 0;
        pc_seen = '0;
        for (int c = 1; c <= 40 && hit_cyc == 0; c++) begin
            @(posedge clk);
            pc <= 64'h8000_2000 + 64'(c * 4);
            @(negedge clk);
            if (in_intr) begin
                hit_cyc = c;
                pc_seen = pc;
            end
        end
        if (hit_cyc == 0) begin
            err_cnt++;
            $display("in_intr_o did not rise within 40 cycles of the mtimecmp store");
        end else if (hit_cyc < 15) begin
            err_cnt++;
            $display("in_intr_o rose after %0d cycles, earlier than 15", hit_cyc);
        end
        csr_access(csr_instr(3'b010, 12'h342, 5'd0), '0, v);
        if (v !== 64'h8000_0000_0000_0007) begin
            report_mismatch("timer_interrupt mcause", 64'h8000_0000_0000_0007, v);
        end
        if (mepc !== pc_seen) report_mismatch("timer_interrupt mepc", pc_seen, mepc);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        arst_n        = 1'b0;
        pc            = '0;
        alures        = '0;
        rs2           = '0;
        instr         = NOP;
        instr_last    = NOP;
        wb_data       = '0;
        trap          = 1'b0;
        sram_rd_valid = 1'b0;
        sram_wr_ok    = 1'b0;
        sram_rd_data  = '0;
        wait_q        = 2'd0;
        lfsr_q        = 16'd16120;
        err_cnt       = 0;
        cur_test      = "";
        for (int i = 0; i < 256; i++) begin
            sram_mem[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1); // distinct word per doubleword
            for (int b = 0; b < 8; b++) ref_b[i*8+b] = sram_mem[i][8*b +: 8];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        load_store();
        store_forward();
        csr_ops();
        trap_mret();
        timer_interrupt();
        $display("ls_stage testbench finished with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
